// File: src/serialFramePkg.sv
`default_nettype none

package serialFramePkg;

	// ************************************************************************
	// Frame layout is start bit, data MSB first, even parity, then stop bits
	// ************************************************************************

	localparam int dataBits = 8;
	localparam int stopBits = 2;
	localparam int frameBits = 1 + dataBits + 1 + stopBits;   // 12 bits on the line

	localparam logic idleLevel = 1'b1;                      // Line rests high

	// Position and bit counters inside one frame
	localparam int bitCntWidth = $clog2(frameBits);
	typedef logic [bitCntWidth-1:0] bitCntT;

endpackage

`default_nettype wire

// File: src/serialCtrlPkg.sv
`default_nettype none

package serialCtrlPkg;

	// ************************************************************************
	// Controller states
	// ************************************************************************

	// Receiver state names what was last sampled from the line
	typedef enum logic [2:0] {
		rxStIdle,
		rxStStart,
		rxStData,
		rxStParity,
		rxStStop,
		rxStDone
	} rxState;

	// Transmitter state names the bit currently driven on the line
	typedef enum logic [2:0] {
		txStIdle,
		txStStart,
		txStData,
		txStParity,
		txStStop
	} txState;

	localparam int countWidth = 16;   // Frame statistics counters

endpackage

`default_nettype wire

// File: src/serialTx.sv
`timescale 1ns/100ps
`default_nettype none

module serialTx
(
	input  wire                                Clk,
	input  wire                                rstN,
	input  wire [serialFramePkg::dataBits-1:0] txData,
	input  wire                                txSend,
	output logic                               txLine,
	output logic                               txBusy
);

	serialCtrlPkg::txState state;
	serialCtrlPkg::txState nextState;

	logic [serialFramePkg::dataBits-1:0] shiftReg;
	serialFramePkg::bitCntT              posCnt;      // Frame position, start bit is 0
	logic                                parityAcc;
	logic                                lastPos;
	logic                                loadByte;

	// Second stop bit is on the line
	assign lastPos = (state == serialCtrlPkg::txStStop) &&
		(posCnt == serialFramePkg::bitCntT'(serialFramePkg::frameBits - 1));

	// Strobe is taken when idle or during the final stop bit
	assign loadByte = txSend && ((state == serialCtrlPkg::txStIdle) || lastPos);

	// ************************************************************************
	// FSM
	// ************************************************************************

	always_comb
	begin
		nextState = state;
		case (state)
			serialCtrlPkg::txStIdle:
				if (txSend)
					nextState = serialCtrlPkg::txStStart;
			serialCtrlPkg::txStStart:
				nextState = serialCtrlPkg::txStData;
			serialCtrlPkg::txStData:
				if (posCnt == serialFramePkg::bitCntT'(serialFramePkg::dataBits))
					nextState = serialCtrlPkg::txStParity;
			serialCtrlPkg::txStParity:
				nextState = serialCtrlPkg::txStStop;
			serialCtrlPkg::txStStop:
				if (lastPos)
					nextState = txSend ? serialCtrlPkg::txStStart : serialCtrlPkg::txStIdle;
			default:
				nextState = serialCtrlPkg::txStIdle;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= serialCtrlPkg::txStIdle;
			posCnt    <= '0;
			parityAcc <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (loadByte)
			begin
				posCnt    <= '0;
				parityAcc <= 1'b0;
			end
			else if (state != serialCtrlPkg::txStIdle)
			begin
				posCnt <= posCnt + 1'b1;
				if (state == serialCtrlPkg::txStData)
					parityAcc <= parityAcc ^ shiftReg[serialFramePkg::dataBits-1];
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (loadByte)
			shiftReg <= txData;
		else if (state == serialCtrlPkg::txStData)
			shiftReg <= {shiftReg[serialFramePkg::dataBits-2:0], 1'b0};   // MSB first
	end

	// Line driver
	always_comb
	begin
		case (state)
			serialCtrlPkg::txStStart:  txLine = ~serialFramePkg::idleLevel;
			serialCtrlPkg::txStData:   txLine = shiftReg[serialFramePkg::dataBits-1];
			serialCtrlPkg::txStParity: txLine = parityAcc;    // Even parity
			default:                   txLine = serialFramePkg::idleLevel;
		endcase
	end

	assign txBusy = (state != serialCtrlPkg::txStIdle);

endmodule

`default_nettype wire

// File: src/serialRx.sv
`timescale 1ns/100ps
`default_nettype none

module serialRx
(
	input  wire                                 Clk,
	input  wire                                 rstN,
	input  wire                                 rxLine,
	output logic                                rxReady,
	output logic                                rxValid,
	output logic [serialFramePkg::dataBits-1:0] rxData,
	output logic                                parityErr,
	output logic                                frameErr,
	output logic                                breakErr
);

	serialCtrlPkg::rxState state;
	serialCtrlPkg::rxState nextState;

	logic [serialFramePkg::dataBits-1:0] dataReg;
	logic [serialFramePkg::stopBits-1:0] stopReg;
	logic [serialFramePkg::stopBits-1:0] stopNext;   // Stop bits including this sample
	logic                                parityReg;
	serialFramePkg::bitCntT              bitCnt;
	logic                                lastSample;
	logic                                parityBad;
	logic                                stopBad;
	logic                                breakSeen;

	assign stopNext = {stopReg[serialFramePkg::stopBits-2:0], rxLine};

	assign lastSample = (state == serialCtrlPkg::rxStStop) &&
		(bitCnt == serialFramePkg::bitCntT'(serialFramePkg::stopBits - 1));

	// Frame checks, taken with the final stop sample
	assign parityBad = (^dataReg) != parityReg;
	assign stopBad   = (stopNext != '1);
	assign breakSeen = (dataReg == '0) && stopBad;

	// ************************************************************************
	// FSM
	// ************************************************************************

	always_comb
	begin
		nextState = state;
		case (state)
			serialCtrlPkg::rxStIdle:
				if (rxLine == ~serialFramePkg::idleLevel)
					nextState = serialCtrlPkg::rxStStart;
			serialCtrlPkg::rxStStart:
				nextState = serialCtrlPkg::rxStData;
			serialCtrlPkg::rxStData:
				if (bitCnt == serialFramePkg::bitCntT'(serialFramePkg::dataBits - 2))
					nextState = serialCtrlPkg::rxStParity;
			serialCtrlPkg::rxStParity:
				nextState = serialCtrlPkg::rxStStop;
			serialCtrlPkg::rxStStop:
				if (lastSample)
					nextState = serialCtrlPkg::rxStDone;
			serialCtrlPkg::rxStDone:
				if (rxLine == serialFramePkg::idleLevel)
					nextState = serialCtrlPkg::rxStIdle;
				else if (&stopReg)   // Clean stop bits, low line is already a new start bit
					nextState = serialCtrlPkg::rxStStart;
			default:
				nextState = serialCtrlPkg::rxStIdle;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state  <= serialCtrlPkg::rxStIdle;
			bitCnt <= '0;
		end
		else
		begin
			state <= nextState;
			if (nextState != state)
				bitCnt <= '0;
			else if ((state == serialCtrlPkg::rxStData) || (state == serialCtrlPkg::rxStStop))
				bitCnt <= bitCnt + 1'b1;
		end
	end

	// Sample capture
	always_ff @(posedge Clk)
	begin
		if ((state == serialCtrlPkg::rxStStart) || (state == serialCtrlPkg::rxStData))
			dataReg <= {dataReg[serialFramePkg::dataBits-2:0], rxLine};
		if (state == serialCtrlPkg::rxStParity)
			parityReg <= rxLine;
		if (state == serialCtrlPkg::rxStStop)
			stopReg <= stopNext;
	end

	// ************************************************************************
	// Result strobe and flags
	// ************************************************************************

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rxValid   <= 1'b0;
			rxData    <= '0;
			parityErr <= 1'b0;
			frameErr  <= 1'b0;
			breakErr  <= 1'b0;
		end
		else
		begin
			rxValid   <= lastSample;
			parityErr <= lastSample && parityBad;
			frameErr  <= lastSample && stopBad;
			breakErr  <= lastSample && breakSeen;
			if (lastSample && !(parityBad || stopBad || breakSeen))
				rxData <= dataReg;
			else
				rxData <= '0;      // Byte shown only for a clean frame
		end
	end

	assign rxReady = (state == serialCtrlPkg::rxStIdle);

endmodule

`default_nettype wire

// File: src/lineStats.sv
`timescale 1ns/100ps
`default_nettype none

module lineStats
(
	input  wire                                 Clk,
	input  wire                                 rstN,
	input  wire                                 rxValid,
	input  wire                                 parityErr,
	input  wire                                 frameErr,
	input  wire                                 breakErr,
	output logic [serialCtrlPkg::countWidth-1:0] goodFrames,
	output logic [serialCtrlPkg::countWidth-1:0] badFrames
);

	logic anyErr;

	// Counter holds at all ones
	function automatic logic [serialCtrlPkg::countWidth-1:0] satInc
	(
		input logic [serialCtrlPkg::countWidth-1:0] cnt
	);
		return (&cnt) ? cnt : cnt + 1'b1;
	endfunction

	assign anyErr = parityErr || frameErr || breakErr;

	// ************************************************************************
	// One classification per result strobe
	// ************************************************************************

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			goodFrames <= '0;
			badFrames  <= '0;
		end
		else if (rxValid)
		begin
			if (anyErr)
				badFrames <= satInc(badFrames);
			else
				goodFrames <= satInc(goodFrames);
		end
	end

endmodule

`default_nettype wire

// File: src/serialLink.sv
`timescale 1ns/100ps
`default_nettype none

module serialLink
(
	input  wire                                  Clk,
	input  wire                                  rstN,
	input  wire [serialFramePkg::dataBits-1:0]   txData,
	input  wire                                  txSend,
	output logic                                 txLine,
	output logic                                 txBusy,
	input  wire                                  rxLine,
	output logic                                 rxReady,
	output logic                                 rxValid,
	output logic [serialFramePkg::dataBits-1:0]  rxData,
	output logic                                 parityErr,
	output logic                                 frameErr,
	output logic                                 breakErr,
	output logic [serialCtrlPkg::countWidth-1:0] goodFrames,
	output logic [serialCtrlPkg::countWidth-1:0] badFrames
);

	// Transmit and receive lines stay apart, the loop is closed outside
	serialTx u_serialTx
	(
		.Clk    (Clk),
		.rstN   (rstN),
		.txData (txData),
		.txSend (txSend),
		.txLine (txLine),
		.txBusy (txBusy)
	);

	serialRx u_serialRx
	(
		.Clk       (Clk),
		.rstN      (rstN),
		.rxLine    (rxLine),
		.rxReady   (rxReady),
		.rxValid   (rxValid),
		.rxData    (rxData),
		.parityErr (parityErr),
		.frameErr  (frameErr),
		.breakErr  (breakErr)
	);

	lineStats u_lineStats
	(
		.Clk        (Clk),
		.rstN       (rstN),
		.rxValid    (rxValid),
		.parityErr  (parityErr),
		.frameErr   (frameErr),
		.breakErr   (breakErr),
		.goodFrames (goodFrames),
		.badFrames  (badFrames)
	);

endmodule

`default_nettype wire

// File: testbench/serialLinkTb.sv
`timescale 1ns/100ps
`default_nettype none

module serialLinkTb;

	localparam int clkPeriod    = 8;
	localparam int resetCycles  = 10;
	localparam int frameLatency = serialFramePkg::frameBits + 1;   // txSend to rxValid
	localparam int parityPos    = serialFramePkg::dataBits + 2;    // Cycles after the strobe
	localparam int stopPos      = parityPos + 1;
	localparam int waitLimit    = 4 * serialFramePkg::frameBits;
	localparam int randomFrames = 6;

	localparam logic [1:0] linePass   = 2'd0;
	localparam logic [1:0] lineInvert = 2'd1;
	localparam logic [1:0] lineLow    = 2'd2;

	logic                                 Clk = 1'b0;
	logic                                 rstN;
	logic [serialFramePkg::dataBits-1:0]  txData;
	logic                                 txSend;
	logic [1:0]                           lineMode;   // What the loop does to txLine
	wire                                  txLine;
	wire                                  txBusy;
	wire                                  rxLine;
	wire                                  rxReady;
	wire                                  rxValid;
	wire  [serialFramePkg::dataBits-1:0]  rxData;
	wire                                  parityErr;
	wire                                  frameErr;
	wire                                  breakErr;
	wire  [serialCtrlPkg::countWidth-1:0] goodFrames;
	wire  [serialCtrlPkg::countWidth-1:0] badFrames;

	int               seed = 8210;
	int               testNum = 0;
	int               passCount = 0;
	int               failCount = 0;
	int               goodTally = 0;
	int               badTally = 0;
	bit               testOk;
	int               fd;
	int               fields;
	logic [7:0]       vData;
	int               vCode;
	logic [7:0]       vRx;
	logic             vPar;
	logic             vFrm;
	logic             vBrk;
	logic [8*128-1:0] lineBuf;
	int               rndWord;
	logic [7:0]       rndByte;

	always #(clkPeriod / 2) Clk = ~Clk;

	assign rxLine = (lineMode == lineInvert) ? ~txLine :
		((lineMode == lineLow) ? 1'b0 : txLine);

	serialLink u_serialLink
	(
		.Clk        (Clk),
		.rstN       (rstN),
		.txData     (txData),
		.txSend     (txSend),
		.txLine     (txLine),
		.txBusy     (txBusy),
		.rxLine     (rxLine),
		.rxReady    (rxReady),
		.rxValid    (rxValid),
		.rxData     (rxData),
		.parityErr  (parityErr),
		.frameErr   (frameErr),
		.breakErr   (breakErr),
		.goodFrames (goodFrames),
		.badFrames  (badFrames)
	);

	task automatic checkValue(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			testOk = 0;
		end
	endtask

	task automatic startTest();
		testNum++;
		testOk = 1;
	endtask

	task automatic finishTest(input string name);
		if (testOk)
			passCount++;
		else
			failCount++;
		$display("Test %0d %s: %s", testNum, name, testOk ? "ok" : "FAILED");
	endtask

	// Returns on a falling edge with the transmitter idle and the receiver ready
	task automatic waitLinkIdle();
		int cycles;
		cycles = 0;
		@(negedge Clk);
		while ((txBusy || !rxReady) && (cycles < waitLimit))
		begin
			@(negedge Clk);
			cycles++;
		end
		if (txBusy || !rxReady)
		begin
			$display("Link still busy after %0d cycles of waiting", cycles);
			testOk = 0;
		end
	endtask

	// ************************************************************************
	// One frame through the loop, code 3 sends a break instead of a byte
	// ************************************************************************

	task automatic runFrame(input logic [7:0] dataByte, input int code,
		input logic [7:0] expData, input logic expPar, input logic expFrm,
		input logic expBrk, input int extraAt);
		int cycle;
		bit seen;
		cycle = 0;
		seen = 0;
		waitLinkIdle();
		@(posedge Clk);   // Cycle 0
		if (code == 3)
			lineMode <= lineLow;
		else
		begin
			txData <= dataByte;
			txSend <= 1'b1;
		end
		while (!seen && (cycle < waitLimit))
		begin
			@(posedge Clk);
			cycle++;
			txSend <= (cycle == extraAt);
			if (cycle == extraAt)
				txData <= ~dataByte;   // Must never reach the line
			if (code == 3)
				lineMode <= (cycle < serialFramePkg::frameBits) ? lineLow : linePass;
			else if ((code == 1) && (cycle == parityPos))
				lineMode <= lineInvert;
			else if ((code == 2) && (cycle == stopPos))
				lineMode <= lineLow;
			else
				lineMode <= linePass;
			@(negedge Clk);
			seen = rxValid;
			if ((code == 3) && !seen)
				checkValue("rxReady during break", rxReady, 0);
		end
		if (!seen)
		begin
			$display("No rxValid within %0d cycles of the frame start", cycle);
			testOk = 0;
		end
		else
		begin
			if (code != 3)
				checkValue("rxValid latency", cycle, frameLatency);
			checkValue("rxData", rxData, expData);
			checkValue("parityErr", parityErr, expPar);
			checkValue("frameErr", frameErr, expFrm);
			checkValue("breakErr", breakErr, expBrk);
			if (code == 3)
				checkValue("rxReady in done state", rxReady, 0);
			if (expPar || expFrm || expBrk)
				badTally++;
			else
				goodTally++;
			@(negedge Clk);
			checkValue("rxValid one cycle later", rxValid, 0);
			checkValue("rxData one cycle later", rxData, 0);
			if (code == 3)
				checkValue("rxReady after line high", rxReady, 1);
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		txData = '0;
		txSend = 1'b0;
		lineMode = linePass;
		repeat (resetCycles) @(posedge Clk);
		rstN <= 1'b1;

		startTest();
		@(negedge Clk);
		checkValue("txLine", txLine, 1);
		checkValue("txBusy", txBusy, 0);
		checkValue("rxReady", rxReady, 1);
		checkValue("rxValid", rxValid, 0);
		checkValue("rxData", rxData, 0);
		checkValue("parityErr", parityErr, 0);
		checkValue("frameErr", frameErr, 0);
		checkValue("breakErr", breakErr, 0);
		checkValue("goodFrames", goodFrames, 0);
		checkValue("badFrames", badFrames, 0);
		finishTest("reset state");

		fd = $fopen("testbench/serialVectors.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the vector file testbench/serialVectors.txt");
			failCount++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				lineBuf = '0;
				if ($fgets(lineBuf, fd) > 0)
				begin
					fields = $sscanf(lineBuf, "%h %h %h %h %h %h",
						vData, vCode, vRx, vPar, vFrm, vBrk);
					if (fields == 6)   // Comment lines do not parse
					begin
						startTest();
						runFrame(vData, vCode, vRx, vPar, vFrm, vBrk, 0);
						finishTest($sformatf("vector %h code %0d", vData, vCode));
					end
				end
			end
			$fclose(fd);
		end

		// Clean random bytes come back unchanged
		for (int i = 0; i < randomFrames; i++)
		begin
			rndWord = $random(seed);
			rndByte = rndWord[7:0];
			startTest();
			runFrame(rndByte, 0, rndByte, 1'b0, 1'b0, 1'b0, 0);
			finishTest($sformatf("random %h", rndByte));
		end

		startTest();
		runFrame(8'h69, 0, 8'h69, 1'b0, 1'b0, 1'b0, 5);
		repeat (2 * serialFramePkg::frameBits)
		begin
			@(negedge Clk);
			if (rxValid)
			begin
				$display("An extra frame came out after a strobe given while txBusy was high");
				testOk = 0;
			end
		end
		finishTest("strobe while busy");

		startTest();
		waitLinkIdle();
		checkValue("goodFrames", goodFrames, goodTally);
		checkValue("badFrames", badFrames, badTally);
		finishTest("frame counters");

		$display("Tests: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
src/serialFramePkg.sv
src/serialCtrlPkg.sv
src/serialTx.sv
src/serialRx.sv
src/lineStats.sv
src/serialLink.sv
testbench/serialLinkTb.sv

// File: testbench/serialVectors.txt
# data corrupt rxData parityErr frameErr breakErr, all hex
# corrupt 0 none, 1 parity bit inverted, 2 first stop bit low, 3 break with data unused
a5 0 a5 0 0 0
3c 0 3c 0 0 0
00 0 00 0 0 0
ff 0 ff 0 0 0
80 0 80 0 0 0
5a 1 00 1 0 0
00 1 00 1 0 0
c3 2 00 0 1 0
00 2 00 0 1 1
01 2 00 0 1 0
00 3 00 0 1 1
e7 0 e7 0 0 0
7f 1 00 1 0 0
00 3 00 0 1 1
96 0 96 0 0 0
